// File: filelist.f
+incdir+src
src/stream_bridge_pkg.sv
src/stream_fifo.sv
src/stream_downsizer.sv
src/stream_upsizer.sv
src/stream_bridge_top.sv
dv/stream_bridge_tb.sv

// File: Makefile
SIM      := verilator
FLAGS    := --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      := stream_bridge_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run, and pass only if the pass line is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)

// File: dv/stream_bridge_tb.sv
/* loopback testbench for the stream bridge, host words in and back out through a core model
   random packets and stalls come from an LFSR, immediate assertions check every transfer */
`timescale 1ns/1ps
`default_nettype none

module stream_bridge_tb;

  logic        i_clk;
  logic        i_rst;
  logic [63:0] i_host_dat;
  logic [2:0]  i_host_mod;
  logic        i_host_eop;
  logic        i_host_val;
  logic        o_host_rdy;
  logic [63:0] o_host_dat;
  logic [2:0]  o_host_mod;
  logic        o_host_eop;
  logic        o_host_val;
  logic        i_host_rdy;
  logic [7:0]  o_core_dat;
  logic        o_core_eop;
  logic        o_core_sop;
  logic        o_core_val;
  logic        i_core_rdy;
  logic [7:0]  i_core_dat;
  logic        i_core_eop;
  logic        i_core_val;
  logic        o_core_rdy;

  logic [31:0] lfsr;                      // random state
  logic [63:0] send_dat [$];              // host words still to drive
  logic [2:0]  send_mod [$];
  logic        send_eop [$];
  logic [63:0] exp_word_dat [$];          // words the host should get back
  logic [2:0]  exp_word_mod [$];
  logic        exp_word_eop [$];
  logic [7:0]  exp_core_dat [$];          // bytes the core should see
  logic        exp_core_eop [$];
  logic [7:0]  loop_dat [$];              // core model, taken but not returned
  logic        loop_eop [$];
  int          total_bytes = 0;
  int          total_words = 0;
  int          words_rcvd = 0;
  int          timeout_cycles = 0;
  logic        host_in_xfer = 1'b0;       // set at posedge, used by the drivers
  logic        core_in_xfer = 1'b0;
  logic        exp_sop = 1'b1;            // next core byte opens a packet
  logic        rst_q = 1'b0;
  logic        core_stall_q = 1'b0;
  logic [7:0]  core_dat_q;
  logic        core_eop_q;
  logic        core_sop_q;
  logic        host_stall_q = 1'b0;
  logic [63:0] host_dat_q;
  logic [2:0]  host_mod_q;
  logic        host_eop_q;

  stream_bridge_top stream_bridge_top_inst (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_host_dat(i_host_dat), .i_host_mod(i_host_mod), .i_host_eop(i_host_eop),
    .i_host_val(i_host_val), .o_host_rdy(o_host_rdy),
    .o_host_dat(o_host_dat), .o_host_mod(o_host_mod), .o_host_eop(o_host_eop),
    .o_host_val(o_host_val), .i_host_rdy(i_host_rdy),
    .o_core_dat(o_core_dat), .o_core_eop(o_core_eop), .o_core_sop(o_core_sop),
    .o_core_val(o_core_val), .i_core_rdy(i_core_rdy),
    .i_core_dat(i_core_dat), .i_core_eop(i_core_eop), .i_core_val(i_core_val),
    .o_core_rdy(o_core_rdy)
  );

  always #50 i_clk = ~i_clk;  // 100 ns period

  // **************************************************
  // helpers
  // **************************************************

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);  // taps 32 22 2 1
  endfunction

  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    int          i;
    v = 0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);  // one step per bit
      v    = (v << 1) | 32'(lfsr[0]);
    end
    return v;
  endfunction

  task automatic fail_msg(input string why);
    $display("%s at %0t", why, $time);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic value_error(input string name, input logic [63:0] exp, input logic [63:0] act);
    fail_msg($sformatf("error: %s expected 0x%0h, actual 0x%0h", name, exp, act));
  endtask

  // one packet of random bytes, split into host words of up to eight lanes
  task automatic build_packet(input int len);
    logic [7:0]  pkt [20];
    logic [63:0] dat;
    int          start;
    int          n;
    int          k;
    for (k = 0; k < len; k++) begin
      pkt[k] = 8'(take_bits(8));
      exp_core_dat.push_back(pkt[k]);
      exp_core_eop.push_back(k == len - 1);  // eop on the last byte only
    end
    for (start = 0; start < len; start += 8) begin
      n   = (len - start < 8) ? len - start : 8;
      dat = '0;  // unused lanes stay zero
      for (k = 0; k < n; k++) begin
        dat[8*k +: 8] = pkt[start + k];
      end
      send_dat.push_back(dat);
      send_mod.push_back(3'(n % 8));  // full word reads as 0
      send_eop.push_back(start + n == len);
      exp_word_dat.push_back(dat);
      exp_word_mod.push_back(3'(n % 8));
      exp_word_eop.push_back(start + n == len);
      total_words++;
    end
    total_bytes += len;
  endtask

  // **************************************************
  // checks, sampled at the rising edge
  // **************************************************

  always @(posedge i_clk) begin
    host_in_xfer = !i_rst && i_host_val && o_host_rdy;
    core_in_xfer = !i_rst && i_core_val && o_core_rdy;
    if (rst_q) begin  // registers already reset
      assert (o_core_val == 1'b0) else value_error("o_core_val", 64'd0, 64'(o_core_val));
      assert (o_host_val == 1'b0) else value_error("o_host_val", 64'd0, 64'(o_host_val));
      assert (o_core_sop == 1'b1) else value_error("o_core_sop", 64'd1, 64'(o_core_sop));
      // both FIFOs empty, so both take input
      assert (o_host_rdy == 1'b1) else value_error("o_host_rdy", 64'd1, 64'(o_host_rdy));
      assert (o_core_rdy == 1'b1) else value_error("o_core_rdy", 64'd1, 64'(o_core_rdy));
    end
    if (!i_rst) begin
      if (core_stall_q) begin  // core held back last cycle
        assert (o_core_val == 1'b1) else value_error("o_core_val", 64'd1, 64'(o_core_val));
        assert (o_core_dat == core_dat_q)
          else value_error("o_core_dat", 64'(core_dat_q), 64'(o_core_dat));
        assert (o_core_eop == core_eop_q)
          else value_error("o_core_eop", 64'(core_eop_q), 64'(o_core_eop));
        assert (o_core_sop == core_sop_q)
          else value_error("o_core_sop", 64'(core_sop_q), 64'(o_core_sop));
      end
      if (host_stall_q) begin
        assert (o_host_val == 1'b1) else value_error("o_host_val", 64'd1, 64'(o_host_val));
        assert (o_host_dat == host_dat_q) else value_error("o_host_dat", host_dat_q, o_host_dat);
        assert (o_host_mod == host_mod_q)
          else value_error("o_host_mod", 64'(host_mod_q), 64'(o_host_mod));
        assert (o_host_eop == host_eop_q)
          else value_error("o_host_eop", 64'(host_eop_q), 64'(o_host_eop));
      end
      if (o_core_val && i_core_rdy) begin
        if (exp_core_dat.size() == 0) fail_msg("core output sent a byte after the last packet");
        assert (o_core_dat == exp_core_dat[0])
          else value_error("o_core_dat", 64'(exp_core_dat[0]), 64'(o_core_dat));
        assert (o_core_eop == exp_core_eop[0])
          else value_error("o_core_eop", 64'(exp_core_eop[0]), 64'(o_core_eop));
        assert (o_core_sop == exp_sop)
          else value_error("o_core_sop", 64'(exp_sop), 64'(o_core_sop));
        exp_sop = exp_core_eop[0];  // next byte opens a packet after eop
        loop_dat.push_back(o_core_dat);  // core model echoes it
        loop_eop.push_back(o_core_eop);
        void'(exp_core_dat.pop_front());
        void'(exp_core_eop.pop_front());
      end
      if (o_host_val && i_host_rdy) begin
        if (exp_word_dat.size() == 0) fail_msg("host output sent a word after the last packet");
        assert (o_host_dat == exp_word_dat[0])
          else value_error("o_host_dat", exp_word_dat[0], o_host_dat);
        assert (o_host_mod == exp_word_mod[0])
          else value_error("o_host_mod", 64'(exp_word_mod[0]), 64'(o_host_mod));
        assert (o_host_eop == exp_word_eop[0])
          else value_error("o_host_eop", 64'(exp_word_eop[0]), 64'(o_host_eop));
        void'(exp_word_dat.pop_front());
        void'(exp_word_mod.pop_front());
        void'(exp_word_eop.pop_front());
        words_rcvd++;
      end
    end
    core_stall_q = !i_rst && o_core_val && !i_core_rdy;
    core_dat_q   = o_core_dat;
    core_eop_q   = o_core_eop;
    core_sop_q   = o_core_sop;
    host_stall_q = !i_rst && o_host_val && !i_host_rdy;
    host_dat_q   = o_host_dat;
    host_mod_q   = o_host_mod;
    host_eop_q   = o_host_eop;
    rst_q        = i_rst;
  end

  // **************************************************
  // drivers, on the falling edge
  // **************************************************

  always @(negedge i_clk) begin
    if (!rst_q) begin  // DUT saw reset low at the last edge
      if (host_in_xfer) begin  // word taken at the last edge
        void'(send_dat.pop_front());
        void'(send_mod.pop_front());
        void'(send_eop.pop_front());
        i_host_val = 1'b0;
      end
      if (!i_host_val && send_dat.size() != 0 && take_bits(2) != 0) begin
        i_host_dat = send_dat[0];
        i_host_mod = send_mod[0];
        i_host_eop = send_eop[0];
        i_host_val = 1'b1;  // held until taken
      end
      if (core_in_xfer) begin
        void'(loop_dat.pop_front());
        void'(loop_eop.pop_front());
        i_core_val = 1'b0;
      end
      if (!i_core_val && loop_dat.size() != 0 && take_bits(2) != 0) begin
        i_core_dat = loop_dat[0];
        i_core_eop = loop_eop[0];
        i_core_val = 1'b1;
      end
      i_core_rdy = (take_bits(2) != 0);  // stall one cycle in four
      i_host_rdy = (take_bits(2) != 0);
    end
  end

  // **************************************************
  // sequence and watchdog
  // **************************************************

  initial begin
    int i;
    i_clk      = 1'b0;
    i_rst      = 1'b1;
    i_host_dat = '0;
    i_host_mod = '0;
    i_host_eop = 1'b0;
    i_host_val = 1'b0;
    i_host_rdy = 1'b0;
    i_core_rdy = 1'b0;
    i_core_dat = '0;
    i_core_eop = 1'b0;
    i_core_val = 1'b0;
    lfsr       = 32'heedd;
    build_packet(1);   // one word, mod 1
    build_packet(8);   // one full eop word
    build_packet(16);  // two words
    for (i = 0; i < 12; i++) begin
      build_packet(1 + int'(take_bits(5) % 20));
    end
    timeout_cycles = 40 * total_bytes + 1000;
    repeat (16) @(negedge i_clk);
    i_rst = 1'b0;
    wait (words_rcvd == total_words);
    repeat (4) @(negedge i_clk);
    if (exp_core_dat.size() != 0 || loop_dat.size() != 0) begin
      fail_msg("bytes left over after the last host word came back");
    end else begin
      $display("Testbench passed");
      $finish;
    end
  end

  initial begin
    #1;  // packet list is built by now
    repeat (timeout_cycles) @(posedge i_clk);
    fail_msg($sformatf("timeout, %0d of %0d host words came back in %0d cycles",
                       words_rcvd, total_words, timeout_cycles));
  end

endmodule

`default_nettype wire

// File: src/stream_bridge_top.sv
/* 64-bit host stream to 8-bit core stream bridge, both directions buffered
   core output gets a regenerated sop, host output gets mod on eop words */
`timescale 1ns/1ps
`default_nettype none

`include "stream_bridge_config.svh"

module stream_bridge_top
  import stream_bridge_pkg::*;
(
  input  wire         i_clk,
  input  wire         i_rst,
  // host in
  input  wire  [63:0] i_host_dat,
  input  wire  [2:0]  i_host_mod,
  input  wire         i_host_eop,
  input  wire         i_host_val,
  output logic        o_host_rdy,
  // host out
  output logic [63:0] o_host_dat,
  output logic [2:0]  o_host_mod,
  output logic        o_host_eop,
  output logic        o_host_val,
  input  wire         i_host_rdy,
  // core out
  output logic [7:0]  o_core_dat,
  output logic        o_core_eop,
  output logic        o_core_sop,
  output logic        o_core_val,
  input  wire         i_core_rdy,
  // core in
  input  wire  [7:0]  i_core_dat,
  input  wire         i_core_eop,
  input  wire         i_core_val,
  output logic        o_core_rdy
);

  word_beat_t host_in_beat;
  word_beat_t word_fifo_beat;
  logic       word_fifo_val;
  logic       word_fifo_rdy;
  byte_beat_t core_out_beat;
  byte_beat_t core_in_beat;
  byte_beat_t byte_fifo_beat;
  logic       byte_fifo_val;
  logic       byte_fifo_rdy;
  word_beat_t host_out_beat;

  // **************************************************
  // host to core
  // **************************************************

  assign host_in_beat = '{dat: i_host_dat, mod: i_host_mod, eop: i_host_eop};

  stream_fifo #(.payload_t(word_beat_t), .DEPTH(`BRIDGE_WORD_FIFO_DEPTH)) u_word_fifo (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_wr_val(i_host_val), .o_wr_rdy(o_host_rdy), .i_wr_beat(host_in_beat),
    .o_rd_val(word_fifo_val), .i_rd_rdy(word_fifo_rdy), .o_rd_beat(word_fifo_beat)
  );

  stream_downsizer u_downsizer (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_word_val(word_fifo_val), .o_word_rdy(word_fifo_rdy), .i_word_beat(word_fifo_beat),
    .o_byte_val(o_core_val), .i_byte_rdy(i_core_rdy), .o_byte_beat(core_out_beat)
  );

  assign o_core_dat = core_out_beat.dat;
  assign o_core_eop = core_out_beat.eop;

  // sop follows the previous transfer's eop, so 1 on every first byte
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_core_sop <= 1'b1;
    end else if (o_core_val && i_core_rdy) begin
      o_core_sop <= o_core_eop;
    end
  end

  // **************************************************
  // core to host
  // **************************************************

  assign core_in_beat = '{dat: i_core_dat, eop: i_core_eop};

  stream_fifo #(.payload_t(byte_beat_t), .DEPTH(`BRIDGE_BYTE_FIFO_DEPTH)) u_byte_fifo (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_wr_val(i_core_val), .o_wr_rdy(o_core_rdy), .i_wr_beat(core_in_beat),
    .o_rd_val(byte_fifo_val), .i_rd_rdy(byte_fifo_rdy), .o_rd_beat(byte_fifo_beat)
  );

  stream_upsizer u_upsizer (
    .i_clk(i_clk), .i_rst(i_rst),
    .i_byte_val(byte_fifo_val), .o_byte_rdy(byte_fifo_rdy), .i_byte_beat(byte_fifo_beat),
    .o_word_val(o_host_val), .i_word_rdy(i_host_rdy), .o_word_beat(host_out_beat)
  );

  assign o_host_dat = host_out_beat.dat;  // lane 0 in the low byte
  assign o_host_mod = host_out_beat.mod;
  assign o_host_eop = host_out_beat.eop;

endmodule

`default_nettype wire

// File: src/stream_upsizer.sv
/* core byte to host word packer, fills lanes from byte 0 upward
   a word closes at eight bytes or on eop, unused lanes read as zero */
`timescale 1ns/1ps
`default_nettype none

module stream_upsizer
  import stream_bridge_pkg::*;
(
  input  wire             i_clk,
  input  wire             i_rst,
  // byte side
  input  wire             i_byte_val,
  output logic            o_byte_rdy,
  input  wire byte_beat_t i_byte_beat,
  // word side
  output logic            o_word_val,
  input  wire             i_word_rdy,
  output word_beat_t      o_word_beat
);

  logic              pend;       // closed word waiting for the host
  logic [WORD_W-1:0] word_q;     // lane accumulator
  logic [LANE_W-1:0] fill;       // next lane to write
  logic [LANE_W-1:0] mod_q;      // filled lanes mod 8
  logic              eop_q;
  logic              byte_xfer;
  logic              word_xfer;
  logic              closing;    // this byte ends the word

  assign o_byte_rdy = !pend;  // no packing while a word waits
  assign o_word_val = pend;
  assign byte_xfer  = i_byte_val && o_byte_rdy;
  assign word_xfer  = o_word_val && i_word_rdy;
  assign closing    = i_byte_beat.eop || (fill == LANE_W'(WORD_BYTES - 1));

  always_comb begin
    o_word_beat.dat = word_q;
    o_word_beat.mod = mod_q;
    o_word_beat.eop = eop_q;
  end

  // **************************************************
  // control
  // **************************************************

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pend <= 1'b0;
      fill <= '0;
    end else if (byte_xfer) begin
      if (closing) begin
        pend <= 1'b1;  // word valid next cycle
        fill <= '0;
      end else begin
        fill <= fill + 1'b1;
      end
    end else if (word_xfer) begin
      pend <= 1'b0;
    end
  end

  // lanes, zeroed so a short eop word has clean upper bytes
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      word_q <= '0;
    end else if (word_xfer) begin
      word_q <= '0;
    end else if (byte_xfer) begin
      word_q[8*fill +: 8] <= i_byte_beat.dat;
    end
  end

  // word framing, set as the word closes
  always_ff @(posedge i_clk) begin
    if (byte_xfer && closing) begin
      eop_q <= i_byte_beat.eop;
      mod_q <= fill + 1'b1;  // eight bytes wraps to 0
    end
  end

  // **************************************************
  // checks
  // **************************************************

  // a word the host holds back must not change under it
  a_word_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_word_val && !i_word_rdy) |=> (o_word_val && $stable(o_word_beat)))
    else $error("stream_upsizer: word changed while stalled");

endmodule

`default_nettype wire

// File: src/stream_downsizer.sv
/* host word to core byte converter, one word in and up to eight bytes out
   the last byte of an eop word carries eop, trimmed by the word's mod */
`timescale 1ns/1ps
`default_nettype none

module stream_downsizer
  import stream_bridge_pkg::*;
(
  input  wire             i_clk,
  input  wire             i_rst,
  // word side
  input  wire             i_word_val,
  output logic            o_word_rdy,
  input  wire word_beat_t i_word_beat,
  // byte side
  output logic            o_byte_val,
  input  wire             i_byte_rdy,
  output byte_beat_t      o_byte_beat
);

  logic              busy;      // word held, bytes going out
  logic [WORD_W-1:0] word_q;    // latched host data
  logic              eop_q;     // latched word was eop
  logic [LANE_W-1:0] idx;       // lane on the output
  logic [LANE_W-1:0] last_idx;  // final lane of this word
  logic              at_last;

  assign o_word_rdy = !busy;  // take a word only when idle
  assign o_byte_val = busy;
  assign at_last    = (idx == last_idx);

  always_comb begin
    o_byte_beat.dat = word_q[8*idx +: 8];  // lane select
    o_byte_beat.eop = eop_q && at_last;    // only on the packet's last lane
  end

  // **************************************************
  // control
  // **************************************************

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      busy <= 1'b0;
      idx  <= '0;
    end else if (!busy) begin
      if (i_word_val) begin
        busy <= 1'b1;
        idx  <= '0;  // byte 0 first
      end
    end else if (i_byte_rdy) begin
      if (at_last) begin
        busy <= 1'b0;  // word done
      end else begin
        idx <= idx + 1'b1;
      end
    end
  end

  // word capture
  always_ff @(posedge i_clk) begin
    if (i_word_val && o_word_rdy) begin
      word_q   <= i_word_beat.dat;
      eop_q    <= i_word_beat.eop;
      // mod 0 wraps to lane 7, i.e. a full eop word
      last_idx <= i_word_beat.eop ? i_word_beat.mod - 1'b1 : LANE_W'(WORD_BYTES - 1);
    end
  end

  // **************************************************
  // checks
  // **************************************************

  // a stalled byte stays on the bus unchanged until the core takes it
  a_byte_hold: assert property (@(posedge i_clk) disable iff (i_rst)
    (o_byte_val && !i_byte_rdy) |=> (o_byte_val && $stable(o_byte_beat)))
    else $error("stream_downsizer: byte changed while stalled");

endmodule

`default_nettype wire

// File: src/stream_fifo.sv
/* single-clock first-word-fall-through FIFO with a typed payload
   instantiated once for host words and once for core bytes */
`timescale 1ns/1ps
`default_nettype none

module stream_fifo #(
  parameter type payload_t = logic [7:0],  // beat held per entry
  parameter int  DEPTH     = 4             // entries, at least 2
) (
  input  wire           i_clk,
  input  wire           i_rst,
  // write side
  input  wire           i_wr_val,
  output logic          o_wr_rdy,
  input  wire payload_t i_wr_beat,
  // read side
  output logic          o_rd_val,
  input  wire           i_rd_rdy,
  output payload_t      o_rd_beat
);

  localparam int PTR_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];  // circular buffer
  logic [PTR_W-1:0] wr_ptr;       // next slot to fill
  logic [PTR_W-1:0] rd_ptr;       // head of queue
  logic [CNT_W-1:0] count;        // entries held
  logic             push;
  logic             pop;

  assign push = i_wr_val && o_wr_rdy;
  assign pop  = o_rd_val && i_rd_rdy;

  assign o_wr_rdy  = (count != CNT_W'(DEPTH));  // room left
  assign o_rd_val  = (count != '0);
  assign o_rd_beat = mem[rd_ptr];               // head shows without a read

  // storage
  always_ff @(posedge i_clk) begin
    if (push) begin
      mem[wr_ptr] <= i_wr_beat;
    end
  end

  // pointers and fill count
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;  // wrap at any depth
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // idle or simultaneous push and pop
      endcase
    end
  end

  // **************************************************
  // checks
  // **************************************************

  // overflow shows up as a count past the array size
  a_count_bound: assert property (@(posedge i_clk) disable iff (i_rst)
    count <= CNT_W'(DEPTH))
    else $error("stream_fifo: count %0d above depth %0d", count, DEPTH);

  // write pointer sits count slots past the read pointer, a lost or doubled beat breaks it
  a_ptr_track: assert property (@(posedge i_clk) disable iff (i_rst)
    int'(wr_ptr) == (int'(rd_ptr) + int'(count)) % DEPTH)
    else $error("stream_fifo: pointers %0d/%0d off count %0d", wr_ptr, rd_ptr, count);

endmodule

`default_nettype wire

// File: src/stream_bridge_pkg.sv
/* beat structs shared by the bridge FIFOs and width converters
   import wherever host words or core bytes are moved as one value */
`default_nettype none

`include "stream_bridge_config.svh"

package stream_bridge_pkg;

  // **************************************************
  // derived sizes
  // **************************************************

  localparam int WORD_BYTES = `BRIDGE_WORD_BYTES;  // lanes per host word
  localparam int WORD_W     = 8 * WORD_BYTES;      // host data bits
  localparam int LANE_W     = $clog2(WORD_BYTES);  // lane index, also mod width

  // **************************************************
  // beat types
  // **************************************************

  // one host beat, byte 0 sits in dat[7:0]
  typedef struct packed {
    logic [WORD_W-1:0] dat;  // lane n at dat[8n +: 8]
    logic [LANE_W-1:0] mod;  // valid bytes on eop word, 0 = all eight
    logic              eop;  // last word of the packet
  } word_beat_t;

  // one core beat
  typedef struct packed {
    logic [7:0] dat;  // payload byte
    logic       eop;  // last byte of the packet
  } byte_beat_t;

endpackage

`default_nettype wire

// File: src/stream_bridge_config.svh
/* bridge sizing macros; include wherever a FIFO depth or the word size is needed
   edit the depths here to trade area against burst absorption */
`ifndef STREAM_BRIDGE_CONFIG_SVH
`define STREAM_BRIDGE_CONFIG_SVH

// **************************************************
// stream widths
// **************************************************

// bytes per host word, core side is one byte
`define BRIDGE_WORD_BYTES 8

// **************************************************
// buffer depths
// **************************************************

// host to core, whole 64-bit words
`define BRIDGE_WORD_FIFO_DEPTH 4

// core to host, single bytes
// deep enough to cover one word plus host stalls
`define BRIDGE_BYTE_FIFO_DEPTH 16

`endif
